/* build.f */
hw/stream_pkg.sv
hw/stream_skidbuf.sv
hw/stream_index_stage.sv
hw/stream_sum_stage.sv
hw/stream_frame_top.sv
+incdir+sim
sim/stream_frame_tb.sv

/* sim/stream_frame_ref.svh */
`ifndef STREAM_FRAME_REF_SVH
`define STREAM_FRAME_REF_SVH

// Packet position and byte sum as the reference model tracks them.
logic [IDX_WIDTH-1:0]  ref_index = '0;
logic [DATA_WIDTH-1:0] ref_sum   = '0;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Expected output for the next input beat in stream order.
function automatic out_beat_t ref_beat(input in_beat_t b);
  out_beat_t e;
  e.data  = b.data;
  e.last  = b.last;
  e.index = ref_index;
  e.sum   = ref_sum + b.data;  // Wraps modulo 256.
  if (b.last) begin
    ref_index = '0;
    ref_sum   = '0;
  end else begin
    ref_index = ref_index + 1'b1;
    ref_sum   = e.sum;
  end
  return e;
endfunction

task automatic check_beat(input out_beat_t got, input out_beat_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("[FAIL] t=%0t %s: got data %h last %b index %0d sum %h", $time, what,
             got.data, got.last, got.index, got.sum);
    $display("       expected data %h last %b index %0d sum %h",
             exp.data, exp.last, exp.index, exp.sum);
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

/* sim/stream_frame_tb.sv */
`timescale 1ns/1ps

module stream_frame_tb
  import stream_pkg::*;
();

  localparam logic [31:0] SEED = 32'h69382806;
  localparam int NUM_PACKETS = 30;
  localparam int READY_HIGH = 0;
  localparam int READY_LOW  = 1;
  localparam int READY_RAND = 2;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  logic      in_ready;
  in_beat_t  in_beat;
  logic      out_valid;
  logic      out_ready;
  out_beat_t out_beat;

  in_beat_t    exp_q[$];  // Accepted input beats not yet seen at the output.
  int          errors = 0;
  int          tests_run = 0;
  int          in_count = 0;
  int          out_count = 0;
  int          cycle = 0;
  int          cycle_limit = 0;
  int          total_beats = 51;  // Single beat, 20-beat and 30-beat packets.
  int          last_in_cycle;
  int          last_out_cycle;
  int          mark_count;
  int          mark_cycle;
  int          err_before;
  int          ready_mode;
  int          pkt_len[NUM_PACKETS];
  logic [31:0] stim_rng = SEED;
  logic [31:0] ready_rng = SEED ^ 32'h5a5a_5a5a;
  logic        saw_stall;
  out_beat_t   last_out;
  out_beat_t   lone_exp;

  `include "stream_frame_ref.svh"

  stream_frame_top #(
    .IDX_WIDTH (IDX_WIDTH)
  ) stream_frame_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  always @(posedge clk) begin
    #1;
    if (ready_mode == READY_LOW) begin
      out_ready = 1'b0;
    end else if (ready_mode == READY_RAND) begin
      ready_rng = xorshift32(ready_rng);
      out_ready = (ready_rng[1:0] != 2'b00);  // High on about three cycles in four.
    end else begin
      out_ready = 1'b1;
    end
  end

  // Both streams are sampled at the falling edge, where every signal is settled.
  always @(negedge clk) begin
    if (in_valid && in_ready) begin
      exp_q.push_back(in_beat);
      in_count++;
      last_in_cycle = cycle;
    end
    if (in_valid && !in_ready) saw_stall = 1'b1;
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output beat at t=%0t arrived with no input beat pending.", $time);
      end else begin
        check_beat(out_beat, ref_beat(exp_q.pop_front()), "out_beat");
      end
      if (out_count == mark_count) mark_cycle = cycle;
      out_count++;
      last_out_cycle = cycle;
      last_out = out_beat;
    end
  end

  initial begin
    wait (cycle_limit > 0);
    while (cycle < cycle_limit) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d beats came out.", cycle, out_count, in_count);
    $display("Done: errors found");
    $finish;
  end

  // Holds one beat on the input until it is taken. Starts and ends just after a rising edge.
  task automatic send_beat(input in_beat_t b);
    in_valid = 1'b1;
    in_beat  = b;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic send_packet(input int len, input bit gaps);
    int       idle;
    in_beat_t b;
    for (int i = 0; i < len; i++) begin
      if (gaps) begin
        stim_rng = xorshift32(stim_rng);
        idle = (stim_rng[3:2] == 2'b00) ? int'(stim_rng[5:4]) + 1 : 0;
        in_valid = 1'b0;
        repeat (idle) begin
          @(posedge clk);
          #1;
        end
      end
      stim_rng = xorshift32(stim_rng);
      b.data = stim_rng[15:8];
      b.last = (i == len - 1);
      send_beat(b);
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    wait (out_count >= in_count);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == err_before) $display("Test %0d %s: passed", tests_run, name);
    else $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
  endtask

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_beat    = '0;
    out_ready  = 1'b0;
    ready_mode = READY_HIGH;
    mark_count = -1;
    saw_stall  = 1'b0;
    for (int k = 0; k < NUM_PACKETS; k++) begin
      stim_rng = xorshift32(stim_rng);
      pkt_len[k] = (k == 2) ? 70 : 1 + int'(stim_rng % 80);  // One packet wraps the index.
      total_beats += pkt_len[k];
    end
    cycle_limit = 4 * total_beats + 1000;

    err_before = errors;
    repeat (15) begin
      @(negedge clk);
      check_bit(out_valid, 1'b0, "out_valid during reset");
      check_bit(in_ready, 1'b1, "in_ready during reset");
    end
    @(posedge clk);
    #1 rst_n = 1'b1;
    // The first edge with reset released has passed at the second falling edge.
    repeat (2) @(negedge clk);
    check_bit(out_valid, 1'b0, "out_valid after reset");
    check_bit(in_ready, 1'b1, "in_ready after reset");
    report_test("reset state");

    err_before = errors;
    lone_exp = '{data: 8'ha5, last: 1'b1, index: '0, sum: 8'ha5};
    @(posedge clk);
    #1 send_beat('{data: 8'ha5, last: 1'b1});
    in_valid = 1'b0;
    wait_drain();
    check_bit((last_out_cycle - last_in_cycle) == 3, 1'b1, "edges from input to output");
    check_beat(last_out, lone_exp, "single beat");
    report_test("latency");

    err_before = errors;
    mark_count = out_count;
    @(posedge clk);
    #1 send_packet(20, 1'b0);
    wait_drain();
    check_bit((last_out_cycle - mark_cycle) == 19, 1'b1, "20 beats on consecutive cycles");
    report_test("full throughput");

    err_before = errors;
    saw_stall = 1'b0;
    @(posedge clk);
    #1;
    fork
      send_packet(30, 1'b0);
      begin
        repeat (6) @(negedge clk);
        ready_mode = READY_LOW;
        repeat (10) @(negedge clk);
        ready_mode = READY_HIGH;
      end
    join
    wait_drain();
    check_bit(saw_stall, 1'b1, "in_ready fell under back-pressure");
    report_test("back-pressure");

    err_before = errors;
    @(negedge clk);
    ready_mode = READY_RAND;
    @(posedge clk);
    #1;
    for (int k = 0; k < NUM_PACKETS; k++) send_packet(pkt_len[k], 1'b1);
    wait_drain();
    @(negedge clk);
    ready_mode = READY_HIGH;
    report_test("random traffic");

    repeat (5) @(negedge clk);
    $display("Summary: %0d tests, %0d beats in, %0d beats out, %0d errors",
             tests_run, in_count, out_count, errors);
    if (errors == 0 && out_count == in_count) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* hw/stream_frame_top.sv */
`timescale 1ns/1ps

module stream_frame_top
  import stream_pkg::*;
#(
  parameter int IDX_WIDTH = 6
) (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      in_valid,
  output logic      in_ready,
  input  in_beat_t  in_beat,

  output logic      out_valid,
  input  logic      out_ready,
  output out_beat_t out_beat
);

  // Input skid buffer to index stage.
  logic      skid_valid;
  logic      skid_ready;
  in_beat_t  skid_beat;

  // Index stage to sum stage.
  logic      tag_valid;
  logic      tag_ready;
  tag_beat_t tag_beat;

  // Sum stage to output skid buffer.
  logic      sum_valid;
  logic      sum_ready;
  out_beat_t sum_beat;

  // No output register here, so the input adds no latency.
  stream_skidbuf #(
    .WIDTH      ($bits(in_beat_t)),
    .OPT_OUTREG (1'b0)
  ) in_skid_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (in_valid),
    .s_ready (in_ready),
    .s_data  (in_beat),
    .m_valid (skid_valid),
    .m_ready (skid_ready),
    .m_data  (skid_beat)
  );

  stream_index_stage #(
    .IDX_WIDTH (IDX_WIDTH)
  ) index_stage_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (skid_valid),
    .in_ready  (skid_ready),
    .in_beat   (skid_beat),
    .out_valid (tag_valid),
    .out_ready (tag_ready),
    .out_beat  (tag_beat)
  );

  stream_sum_stage sum_stage_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (tag_valid),
    .in_ready  (tag_ready),
    .in_beat   (tag_beat),
    .out_valid (sum_valid),
    .out_ready (sum_ready),
    .out_beat  (sum_beat)
  );

  // Registered output, so every output port comes from a flop.
  stream_skidbuf #(
    .WIDTH      ($bits(out_beat_t)),
    .OPT_OUTREG (1'b1)
  ) out_skid_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (sum_valid),
    .s_ready (sum_ready),
    .s_data  (sum_beat),
    .m_valid (out_valid),
    .m_ready (out_ready),
    .m_data  (out_beat)
  );

endmodule

/* hw/stream_sum_stage.sv */
`timescale 1ns/1ps

module stream_sum_stage
  import stream_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      in_valid,
  output logic      in_ready,
  input  tag_beat_t in_beat,

  output logic      out_valid,
  input  logic      out_ready,
  output out_beat_t out_beat
);

  logic [DATA_WIDTH-1:0] acc;
  logic [DATA_WIDTH-1:0] sum_now;
  logic                  valid_q;
  out_beat_t             beat_q;
  logic                  accept;

  assign in_ready  = !valid_q || out_ready;
  assign accept    = in_valid && in_ready;

  assign out_valid = valid_q;
  assign out_beat  = beat_q;

  // Sum of the packet up to and including the current beat, modulo 256.
  assign sum_now = acc + in_beat.data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      acc     <= '0;
    end else if (accept) begin
      valid_q <= 1'b1;
      if (in_beat.last) begin
        acc <= '0;  // Next packet starts from zero.
      end else begin
        acc <= sum_now;
      end
    end else if (out_ready) begin
      valid_q <= 1'b0;
    end
  end

  // The beat is held here while the output is stalled.
  always_ff @(posedge clk) begin
    if (accept) begin
      beat_q.data  <= in_beat.data;
      beat_q.last  <= in_beat.last;
      beat_q.index <= in_beat.index;
      beat_q.sum   <= sum_now;
    end
  end

endmodule

/* hw/stream_index_stage.sv */
`timescale 1ns/1ps

module stream_index_stage
  import stream_pkg::*;
#(
  parameter int IDX_WIDTH = stream_pkg::IDX_WIDTH
) (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      in_valid,
  output logic      in_ready,
  input  in_beat_t  in_beat,

  output logic      out_valid,
  input  logic      out_ready,
  output tag_beat_t out_beat
);

  // Width of the index field as laid out in the struct.
  localparam int FIELD_WIDTH = $bits(tag_beat_t) - $bits(in_beat_t);

  logic [IDX_WIDTH-1:0] beat_cnt;
  logic                 valid_q;
  tag_beat_t            beat_q;
  logic                 accept;

  // The register can take a beat when it is empty or drains this cycle.
  assign in_ready  = !valid_q || out_ready;
  assign accept    = in_valid && in_ready;

  assign out_valid = valid_q;
  assign out_beat  = beat_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q  <= 1'b0;
      beat_cnt <= '0;
    end else if (accept) begin
      valid_q <= 1'b1;
      // The counter restarts after the last beat and wraps on long packets.
      if (in_beat.last) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end else if (out_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      beat_q.data  <= in_beat.data;
      beat_q.last  <= in_beat.last;
      beat_q.index <= FIELD_WIDTH'(beat_cnt);  // Position of this beat in its packet.
    end
  end

endmodule

/* hw/stream_skidbuf.sv */
`timescale 1ns/1ps

module stream_skidbuf #(
  parameter int WIDTH      = 8,
  parameter bit OPT_OUTREG = 1'b0
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             s_valid,
  output logic             s_ready,
  input  logic [WIDTH-1:0] s_data,

  output logic             m_valid,
  input  logic             m_ready,
  output logic [WIDTH-1:0] m_data
);

  logic             skid_valid;
  logic             skid_valid_next;
  logic [WIDTH-1:0] skid_data;
  logic             ready_q;
  logic             s_accept;

  assign s_ready  = ready_q;
  assign s_accept = s_valid && ready_q;

  // A beat accepted while the output stalls is parked in the skid slot.
  always_comb begin
    skid_valid_next = skid_valid;
    if (s_accept && m_valid && !m_ready) begin
      skid_valid_next = 1'b1;
    end else if (m_ready) begin
      skid_valid_next = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_valid <= 1'b0;
      ready_q    <= 1'b1;
    end else begin
      skid_valid <= skid_valid_next;
      ready_q    <= !skid_valid_next;  // Ready only while the slot is empty.
    end
  end

  // The slot can only be written while it is empty, so the parked beat is never overwritten.
  always_ff @(posedge clk) begin
    if (s_accept) begin
      skid_data <= s_data;
    end
  end

  generate
    if (OPT_OUTREG) begin : g_outreg
      logic             out_valid_q;
      logic [WIDTH-1:0] out_data_q;
      logic             out_load;

      // The output register takes a new beat when it is empty or being drained.
      assign out_load = !out_valid_q || m_ready;

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          out_valid_q <= 1'b0;
        end else if (out_load) begin
          out_valid_q <= s_valid || skid_valid;
        end
      end

      // The parked beat is older than anything on the input, so it goes first.
      always_ff @(posedge clk) begin
        if (out_load) begin
          if (skid_valid) begin
            out_data_q <= skid_data;
          end else begin
            out_data_q <= s_data;
          end
        end
      end

      assign m_valid = out_valid_q;
      assign m_data  = out_data_q;
    end else begin : g_bypass
      // With an empty slot the input passes straight through.
      assign m_valid = s_valid || skid_valid;
      assign m_data  = skid_valid ? skid_data : s_data;
    end
  endgenerate

endmodule

/* hw/stream_pkg.sv */
package stream_pkg;

  // The running sum is taken modulo 2**DATA_WIDTH.
  localparam int DATA_WIDTH = 8;
  localparam int IDX_WIDTH  = 6;  // Beat index wraps at 64.

  // Payload of the input stream.
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } in_beat_t;

  // Payload between the index stage and the sum stage.
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
    logic [IDX_WIDTH-1:0]  index;
  } tag_beat_t;

  // Payload of the output stream.
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
    logic [IDX_WIDTH-1:0]  index;
    logic [DATA_WIDTH-1:0] sum;
  } out_beat_t;

endpackage
